// ==== build.f ====
+incdir+source
source/bp_pkg.sv
source/bp_history_table.sv
source/bp_target_buffer.sv
source/bp_resolver.sv
source/branch_predictor.sv
tb/bp_checker.sv
tb/bp_sva.sv
tb/bp_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds and runs the branch predictor testbench with Verilator
# Run from the project root; exits non-zero on failure

rm -f sim.log

verilator --binary --timing --assert --top-module bp_tb -f build.f -o bp_sim \
  > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/bp_sim > sim.log 2>&1 ; cat sim.log

grep -q "sim failed" sim.log && { echo "simulation reported failure"; exit 1; } \
  || grep -q "sim passed" sim.log || { echo "no verdict in sim.log"; exit 1; }

exit 0

// ==== source/bp_history_table.sv ====
// Direct-mapped tagged branch history table with 8 entries
// Combinational read where a tag miss reads as STRONG_NOT_TAKEN
// A write lands on the next rising edge so a same-cycle read sees old data
// wen must already be qualified by the caller

`timescale 1ns/1ps
`default_nettype none

`include "bp_settings.svh"

module bp_history_table (
  input  wire logic                  clk,
  input  wire logic                  rst,
  input  wire logic [`BP_PC_W-1:0]   pc_fetch,        // Fetch stage PC
  output logic                       hit,             // Valid entry with matching tag
  output bp_pkg::counter_t           counter,         // Counter of the fetch PC
  output logic                       predicted_taken, // Upper counter bit
  input  wire logic                  wen,             // Update strobe from resolver
  input  wire logic [`BP_PC_W-1:0]   wr_pc,           // PC of the resolved branch
  input  wire bp_pkg::counter_t      old_counter,     // Counter read at fetch time
  input  wire logic                  actual_taken     // Resolved direction
);

  import bp_pkg::*;

  ////////////////////
  // Storage
  ////////////////////

  logic                  valid_q [`BP_ENTRIES];  // Entry holds a branch
  logic [`BP_TAG_W-1:0]  tag_q   [`BP_ENTRIES];  // Upper PC bits
  counter_t              cnt_q   [`BP_ENTRIES];  // Saturating counters

  logic [`BP_IDX_W-1:0]  rd_idx;                 // Fetch side index
  logic [`BP_TAG_W-1:0]  rd_tag;                 // Fetch side tag
  logic [`BP_IDX_W-1:0]  wr_idx;                 // Update side index
  logic [`BP_TAG_W-1:0]  wr_tag;                 // Update side tag
  counter_t              next_counter;           // Counter after the update

  assign rd_idx = pc_fetch[`BP_IDX_W:1];
  assign rd_tag = pc_fetch[`BP_PC_W-1:`BP_IDX_W+1];
  assign wr_idx = wr_pc[`BP_IDX_W:1];
  assign wr_tag = wr_pc[`BP_PC_W-1:`BP_IDX_W+1];

  ////////////////////
  // Fetch read
  ////////////////////

  assign hit             = valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);
  assign counter         = hit ? cnt_q[rd_idx] : STRONG_NOT_TAKEN; // Miss reads strongly not taken
  assign predicted_taken = counter[1];

  ////////////////////
  // Counter update
  ////////////////////

  // One step toward the resolved direction and held at both ends
  always_comb begin
    next_counter = old_counter;
    case (old_counter)
      STRONG_NOT_TAKEN: next_counter = actual_taken ? WEAK_NOT_TAKEN : STRONG_NOT_TAKEN;
      WEAK_NOT_TAKEN:   next_counter = actual_taken ? WEAK_TAKEN     : STRONG_NOT_TAKEN;
      WEAK_TAKEN:       next_counter = actual_taken ? STRONG_TAKEN   : WEAK_NOT_TAKEN;
      STRONG_TAKEN:     next_counter = actual_taken ? STRONG_TAKEN   : WEAK_TAKEN;
    endcase
  end

  // Reset empties every entry
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `BP_ENTRIES; i++) begin
        valid_q[i] <= 1'b0;
        cnt_q[i]   <= STRONG_NOT_TAKEN;
      end
    end else if (wen) begin
      valid_q[wr_idx] <= 1'b1;          // Claims the entry and may evict an alias
      cnt_q[wr_idx]   <= next_counter;
    end
  end

  always_ff @(posedge clk) begin
    if (wen) begin
      tag_q[wr_idx] <= wr_tag;          // New owner of the index
    end
  end

endmodule

`default_nettype wire

// ==== source/bp_pkg.sv ====
// Shared types of the branch prediction subsystem
// Counter encoding is fixed, upper bit is the taken prediction

`default_nettype none

package bp_pkg;

  // 2-bit saturating counter, every encoding is a legal state
  typedef enum logic [1:0] {
    STRONG_NOT_TAKEN = 2'b00,
    WEAK_NOT_TAKEN   = 2'b01,
    WEAK_TAKEN       = 2'b10,
    STRONG_TAKEN     = 2'b11
  } counter_t;

  // Outcome of the IF/ID slot in the decode stage
  typedef enum logic [1:0] {
    RES_NONE     = 2'b00,   // Nothing resolved this cycle
    RES_CORRECT  = 2'b01,   // Direction and target right
    RES_DIR_MISS = 2'b10,   // Wrong direction
    RES_TGT_MISS = 2'b11    // Taken as predicted, wrong target
  } resolve_t;

endpackage

`default_nettype wire

// ==== source/bp_resolver.sv ====
// Decode-stage branch resolution, purely combinational
// Only this block qualifies table writes with enable and slot validity
// redirect_pc is always computed, it is acted on only with mispredict

`timescale 1ns/1ps
`default_nettype none

`include "bp_settings.svh"

module bp_resolver (
  input  wire logic                  id_valid,        // IF/ID slot holds a live fetch
  input  wire logic [`BP_PC_W-1:0]   id_pc,           // PC of the slot
  input  wire logic                  id_pred_taken,   // Direction guessed at fetch
  input  wire logic [`BP_PC_W-1:0]   id_pred_target,  // Target guessed at fetch
  input  wire logic                  branch_valid,    // Decode sees a branch
  input  wire logic                  actual_taken,    // Resolved direction
  input  wire logic [`BP_PC_W-1:0]   actual_target,   // Resolved target
  input  wire logic                  enable,          // Low during a stall
  output logic                       bht_wen,         // Update the history entry
  output logic                       btb_wen,         // Update the target entry
  output logic                       mispredict,      // Single cycle redirect request
  output logic [`BP_PC_W-1:0]        redirect_pc,     // Correct next fetch PC
  output bp_pkg::resolve_t           resolve_kind     // Slot classification
);

  import bp_pkg::*;

  logic                  resolved;      // A branch is resolved this cycle
  logic                  dir_wrong;     // Direction disagrees
  logic                  tgt_wrong;     // Guessed target differs from real one
  logic [`BP_PC_W-1:0]   fall_through;  // Next sequential PC of the slot
  resolve_t              kind;

  ////////////////////
  // Qualification
  ////////////////////

  // Stalls and squashed slots never resolve
  assign resolved = enable && id_valid && branch_valid;

  assign dir_wrong    = (actual_taken != id_pred_taken);
  assign tgt_wrong    = (actual_target != id_pred_target);
  assign fall_through = id_pc + `BP_PC_W'(`BP_INSN_BYTES);

  ////////////////////
  // Classification
  ////////////////////

  always_comb begin
    kind = RES_NONE;
    if (resolved) begin
      if (dir_wrong) begin
        kind = RES_DIR_MISS;                  // Covers both taken and not-taken misses
      end else if (actual_taken && tgt_wrong) begin
        kind = RES_TGT_MISS;                  // Right direction, stale target
      end else begin
        kind = RES_CORRECT;
      end
    end
  end

  assign resolve_kind = kind;
  assign mispredict   = (kind == RES_DIR_MISS) || (kind == RES_TGT_MISS);

  ////////////////////
  // Table updates
  ////////////////////

  // Counter moves on every resolved branch
  assign bht_wen = resolved;

  // A BTB miss reads back as the fall-through PC, so a target compare
  // also catches a missing entry unless the branch targets pc + 2
  assign btb_wen = resolved && actual_taken && tgt_wrong;

  ////////////////////
  // Redirect
  ////////////////////

  assign redirect_pc = actual_taken ? actual_target : fall_through;

endmodule

`default_nettype wire

// ==== source/bp_settings.svh ====
// Sizing for the branch prediction subsystem
// Assumes 2-byte instructions, so PC bit 0 never takes part in indexing
// Index and tag must together cover PC bits 15 to 1

`ifndef BP_SETTINGS_SVH
`define BP_SETTINGS_SVH

////////////////////
// PC and tables
////////////////////

`define BP_PC_W        16   // Width of every PC and target
`define BP_IDX_W       3    // Table index, PC bits 3 to 1
`define BP_TAG_W       12   // Tag, PC bits 15 to 4
`define BP_ENTRIES     8    // Entries per table, 2 ** BP_IDX_W
`define BP_INSN_BYTES  2    // Fall-through step of the PC

`endif

// ==== source/bp_target_buffer.sv ====
// Direct-mapped tagged branch target buffer, 8 entries
// Target output is only meaningful while btb_hit is set
// A write replaces the whole indexed entry on the next rising edge

`timescale 1ns/1ps
`default_nettype none

`include "bp_settings.svh"

module bp_target_buffer (
  input  wire logic                  clk,
  input  wire logic                  rst,
  input  wire logic [`BP_PC_W-1:0]   pc_fetch,   // Fetch stage PC
  output logic                       btb_hit,    // Valid entry with matching tag
  output logic [`BP_PC_W-1:0]        target,     // Stored target of the entry
  input  wire logic                  wen,        // Write strobe from resolver
  input  wire logic [`BP_PC_W-1:0]   wr_pc,      // PC of the taken branch
  input  wire logic [`BP_PC_W-1:0]   wr_target   // Its actual target
);

  ////////////////////
  // Storage
  ////////////////////

  logic                  valid_q  [`BP_ENTRIES];
  logic [`BP_TAG_W-1:0]  tag_q    [`BP_ENTRIES];
  logic [`BP_PC_W-1:0]   target_q [`BP_ENTRIES];

  logic [`BP_IDX_W-1:0]  rd_idx;
  logic [`BP_IDX_W-1:0]  wr_idx;

  assign rd_idx = pc_fetch[`BP_IDX_W:1];     // PC bits 3 to 1
  assign wr_idx = wr_pc[`BP_IDX_W:1];

  ////////////////////
  // Fetch read
  ////////////////////

  assign btb_hit = valid_q[rd_idx] &&
                   (tag_q[rd_idx] == pc_fetch[`BP_PC_W-1:`BP_IDX_W+1]);
  assign target  = target_q[rd_idx];

  ////////////////////
  // Update
  ////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `BP_ENTRIES; i++) begin
        valid_q[i] <= 1'b0;             // All entries empty
      end
    end else if (wen) begin
      valid_q[wr_idx] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (wen) begin
      tag_q[wr_idx]    <= wr_pc[`BP_PC_W-1:`BP_IDX_W+1];
      target_q[wr_idx] <= wr_target;    // Last taken target wins
    end
  end

endmodule

`default_nettype wire

// ==== source/branch_predictor.sv ====
// Branch prediction subsystem top level
// Predicts combinationally from pc_fetch, resolves in the same cycle as decode
// enable low freezes the IF/ID slot and blocks all table writes
// The fetch after a mispredict is dropped from the IF/ID slot

`timescale 1ns/1ps
`default_nettype none

`include "bp_settings.svh"

module branch_predictor (
  input  wire logic                  clk,
  input  wire logic                  rst,
  input  wire logic                  enable,            // Pipeline advance
  input  wire logic                  fetch_valid,       // pc_fetch is a real fetch
  input  wire logic [`BP_PC_W-1:0]   pc_fetch,
  output logic                       predicted_taken,
  output logic [`BP_PC_W-1:0]        predicted_target,
  input  wire logic                  branch_valid,      // Decode found a branch in the slot
  input  wire logic                  actual_taken,
  input  wire logic [`BP_PC_W-1:0]   actual_target,
  output logic                       mispredict,
  output logic [`BP_PC_W-1:0]        redirect_pc,
  output bp_pkg::resolve_t           resolve_kind
);

  import bp_pkg::*;

  ////////////////////
  // Fetch prediction
  ////////////////////

  logic                  bht_hit;
  counter_t              bht_counter;
  logic                  bht_taken;
  logic                  btb_hit;
  logic [`BP_PC_W-1:0]   btb_target;
  logic                  bht_wen;
  logic                  btb_wen;

  // IF/ID slot
  logic                  id_valid;
  logic [`BP_PC_W-1:0]   id_pc;
  counter_t              id_counter;        // Counter as read at fetch
  logic                  id_pred_taken;
  logic [`BP_PC_W-1:0]   id_pred_target;

  assign predicted_taken  = bht_hit && bht_taken;   // Untracked PCs fall through
  assign predicted_target = btb_hit ? btb_target : pc_fetch + `BP_PC_W'(`BP_INSN_BYTES);

  bp_history_table u_bht (
    .clk             (clk),
    .rst             (rst),
    .pc_fetch        (pc_fetch),
    .hit             (bht_hit),
    .counter         (bht_counter),
    .predicted_taken (bht_taken),
    .wen             (bht_wen),
    .wr_pc           (id_pc),
    .old_counter     (id_counter),
    .actual_taken    (actual_taken)
  );

  bp_target_buffer u_btb (
    .clk       (clk),
    .rst       (rst),
    .pc_fetch  (pc_fetch),
    .btb_hit   (btb_hit),
    .target    (btb_target),
    .wen       (btb_wen),
    .wr_pc     (id_pc),
    .wr_target (actual_target)
  );

  ////////////////////
  // IF/ID slot
  ////////////////////

  // Wrong-path fetch enters the slot as a bubble
  always_ff @(posedge clk) begin
    if (rst) begin
      id_valid <= 1'b0;
    end else if (enable) begin
      id_valid <= fetch_valid && !mispredict;
    end
  end

  // Payload only moves with the pipeline
  always_ff @(posedge clk) begin
    if (enable) begin
      id_pc          <= pc_fetch;
      id_counter     <= bht_counter;
      id_pred_taken  <= predicted_taken;
      id_pred_target <= predicted_target;
    end
  end

  ////////////////////
  // Decode resolution
  ////////////////////

  bp_resolver u_resolver (
    .id_valid       (id_valid),
    .id_pc          (id_pc),
    .id_pred_taken  (id_pred_taken),
    .id_pred_target (id_pred_target),
    .branch_valid   (branch_valid),
    .actual_taken   (actual_taken),
    .actual_target  (actual_target),
    .enable         (enable),
    .bht_wen        (bht_wen),
    .btb_wen        (btb_wen),
    .mispredict     (mispredict),
    .redirect_pc    (redirect_pc),
    .resolve_kind   (resolve_kind)
  );

endmodule

`default_nettype wire

// ==== tb/bp_cases.txt ====
// enable fetch_valid pc_fetch branch_valid actual_taken actual_target exp_mispredict exp_redirect
// hex columns, one line per cycle, exp_redirect is checked only when exp_mispredict is 1
1 1 0010 0 0 0000 0 0000
1 1 0040 1 1 0100 1 0100
1 1 0010 0 0 0000 0 0000
1 1 0040 1 1 0100 1 0100
1 1 0010 0 0 0000 0 0000
1 1 0040 1 1 0100 0 0000
1 1 0010 0 0 0000 0 0000
1 1 0040 1 1 0100 0 0000
1 1 0010 0 0 0000 0 0000
1 1 0040 1 0 0000 1 0012
1 1 0010 0 0 0000 0 0000
1 1 0040 1 0 0000 1 0012
1 1 0010 0 0 0000 0 0000
1 1 0040 1 1 0100 1 0100
1 1 0010 0 0 0000 0 0000
1 1 0040 1 1 0200 1 0200
1 1 0010 0 0 0000 0 0000
1 1 0040 1 1 0200 0 0000
1 1 0020 0 0 0000 0 0000
1 1 0040 1 1 0300 1 0300
1 1 0010 0 0 0000 0 0000
1 1 0040 1 0 0000 0 0000
1 1 0010 0 0 0000 0 0000
0 1 0040 1 1 0500 0 0000
0 1 0040 1 1 0500 0 0000
1 1 0040 1 1 0500 1 0500
1 1 0050 1 1 0600 0 0000
1 1 0010 0 0 0000 0 0000
1 0 0000 1 0 0000 0 0000
1 0 0000 0 0 0000 0 0000

// ==== tb/bp_checker.sv ====
// Reference model of the BHT, BTB and IF/ID slot
// Samples on the falling edge where inputs and outputs have settled
// Model state advances after the compare on the same falling edge
// redirect_pc is compared only in cycles with a resolved branch

`timescale 1ns/1ps
`default_nettype none

`include "bp_settings.svh"

module bp_checker (
  input  wire logic                 clk,
  input  wire logic                 rst,
  input  wire logic                 enable,
  input  wire logic                 fetch_valid,
  input  wire logic [`BP_PC_W-1:0]  pc_fetch,
  input  wire logic                 predicted_taken,
  input  wire logic [`BP_PC_W-1:0]  predicted_target,
  input  wire logic                 branch_valid,
  input  wire logic                 actual_taken,
  input  wire logic [`BP_PC_W-1:0]  actual_target,
  input  wire logic                 mispredict,
  input  wire logic [`BP_PC_W-1:0]  redirect_pc,
  input  wire bp_pkg::resolve_t     resolve_kind,
  input  wire logic                 exp_valid,       // Case file values apply
  input  wire logic                 exp_mispredict,
  input  wire logic [`BP_PC_W-1:0]  exp_redirect,
  output int                        error_count,
  output int                        check_count
);

  import bp_pkg::*;

  ////////////////////
  // Model state
  ////////////////////

  logic                 h_valid [`BP_ENTRIES];
  logic [`BP_TAG_W-1:0] h_tag   [`BP_ENTRIES];
  counter_t             h_cnt   [`BP_ENTRIES];
  logic                 b_valid [`BP_ENTRIES];
  logic [`BP_TAG_W-1:0] b_tag   [`BP_ENTRIES];
  logic [`BP_PC_W-1:0]  b_tgt   [`BP_ENTRIES];

  logic                 s_valid;          // IF/ID copy
  logic [`BP_PC_W-1:0]  s_pc;
  counter_t             s_cnt;
  logic                 s_ptaken;
  logic [`BP_PC_W-1:0]  s_ptgt;

  initial begin
    error_count = 0;
    check_count = 0;
  end

  // Saturating step of a 2-bit counter
  function automatic counter_t step_counter(counter_t c, logic taken);
    if (taken) begin
      return (c == STRONG_TAKEN) ? c : counter_t'(c + 2'd1);
    end
    return (c == STRONG_NOT_TAKEN) ? c : counter_t'(c - 2'd1);
  endfunction

  task automatic compare(string name, logic [15:0] got, logic [15:0] exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("[FAIL] %0t %s got 0x%04h expected 0x%04h", $time, name, got, exp);
    end
  endtask

  ////////////////////
  // Per-cycle check
  ////////////////////

  always @(negedge clk) begin : model_step
    logic [`BP_IDX_W-1:0] ridx;
    logic [`BP_IDX_W-1:0] widx;
    logic                 hit;
    logic                 bhit;
    counter_t             cnt;
    logic                 ptaken;
    logic [`BP_PC_W-1:0]  ptgt;
    logic                 resolved;
    resolve_t             kind;
    logic                 mp;
    logic [`BP_PC_W-1:0]  redir;

    ridx   = pc_fetch[3:1];
    hit    = h_valid[ridx] && (h_tag[ridx] == pc_fetch[15:4]);
    cnt    = hit ? h_cnt[ridx] : STRONG_NOT_TAKEN;
    ptaken = cnt[1];                      // Upper bit predicts taken
    bhit   = b_valid[ridx] && (b_tag[ridx] == pc_fetch[15:4]);
    ptgt   = bhit ? b_tgt[ridx] : pc_fetch + 16'd2;

    resolved = enable && s_valid && branch_valid;
    if (!resolved) begin
      kind = RES_NONE;
    end else if (actual_taken != s_ptaken) begin
      kind = RES_DIR_MISS;
    end else if (actual_taken && actual_target != s_ptgt) begin
      kind = RES_TGT_MISS;
    end else begin
      kind = RES_CORRECT;
    end
    mp    = (kind == RES_DIR_MISS) || (kind == RES_TGT_MISS);
    redir = actual_taken ? actual_target : s_pc + 16'd2;

    if (rst) begin
      for (int i = 0; i < `BP_ENTRIES; i++) begin
        h_valid[i] = 1'b0;
        h_cnt[i]   = STRONG_NOT_TAKEN;
        b_valid[i] = 1'b0;
      end
      s_valid = 1'b0;
    end else begin
      compare("predicted_taken", 16'(predicted_taken), 16'(ptaken));
      compare("predicted_target", predicted_target, ptgt);
      compare("mispredict", 16'(mispredict), 16'(mp));
      compare("resolve_kind", 16'(resolve_kind), 16'(kind));
      if (resolved) begin
        compare("redirect_pc", redirect_pc, redir);
      end
      if (exp_valid) begin
        compare("mispredict vs case file", 16'(mispredict), 16'(exp_mispredict));
        if (exp_mispredict) begin
          compare("redirect_pc vs case file", redirect_pc, exp_redirect);
        end
      end

      // Table writes become visible to the next cycle's fetch
      widx = s_pc[3:1];
      if (resolved) begin
        h_valid[widx] = 1'b1;
        h_tag[widx]   = s_pc[15:4];
        h_cnt[widx]   = step_counter(s_cnt, actual_taken);
        if (actual_taken && actual_target != s_ptgt) begin
          b_valid[widx] = 1'b1;
          b_tag[widx]   = s_pc[15:4];
          b_tgt[widx]   = actual_target;
        end
      end
      if (enable) begin
        s_valid  = fetch_valid && !mp;    // Wrong-path fetch becomes a bubble
        s_pc     = pc_fetch;
        s_cnt    = cnt;
        s_ptaken = ptaken;
        s_ptgt   = ptgt;
      end
    end
  end

endmodule

`default_nettype wire

// ==== tb/bp_sva.sv ====
// Concurrent checks on the branch predictor top level, attached with bind
// Sampled on the rising clock edge

`timescale 1ns/1ps
`default_nettype none

module bp_sva (
  input wire logic clk,
  input wire logic rst,
  input wire logic enable,
  input wire logic bht_wen,
  input wire logic btb_wen,
  input wire logic mispredict,
  input wire logic actual_taken,
  input wire logic id_valid
);

  // Stalls and the first cycle out of reset are quiet
  assert property (@(posedge clk) disable iff (rst)
    (!enable || $past(rst)) |-> !(bht_wen || btb_wen || mispredict))
    else $error("table write or mispredict during stall or right after reset");

  // Targets are only learned from taken branches
  assert property (@(posedge clk) disable iff (rst) btb_wen |-> actual_taken)
    else $error("btb_wen without actual_taken");

  // Squash of the wrong-path slot
  assert property (@(posedge clk) disable iff (rst) mispredict |=> !id_valid)
    else $error("IF/ID slot still valid after a mispredict");

endmodule

bind branch_predictor bp_sva u_sva (
  .clk          (clk),
  .rst          (rst),
  .enable       (enable),
  .bht_wen      (bht_wen),
  .btb_wen      (btb_wen),
  .mispredict   (mispredict),
  .actual_taken (actual_taken),
  .id_valid     (id_valid)
);

`default_nettype wire

// ==== tb/bp_tb.sv ====
// Testbench top for the branch prediction subsystem
// Replays tb/bp_cases.txt line by line and then runs 400 random cycles
// One case line is one clock cycle and its redirect column counts only with mispredict
// bp_checker does the comparing and counts the errors

`timescale 1ns/1ps
`default_nettype none

`include "bp_settings.svh"

module bp_tb;

  import bp_pkg::*;

  localparam int MAX_CASES  = 64;
  localparam int RAND_CYCLES = 400;

  logic                 clk;
  logic                 rst;
  logic                 enable;
  logic                 fetch_valid;
  logic [`BP_PC_W-1:0]  pc_fetch;
  logic                 predicted_taken;
  logic [`BP_PC_W-1:0]  predicted_target;
  logic                 branch_valid;
  logic                 actual_taken;
  logic [`BP_PC_W-1:0]  actual_target;
  logic                 mispredict;
  logic [`BP_PC_W-1:0]  redirect_pc;
  resolve_t             resolve_kind;

  logic                 exp_valid;        // Current cycle comes from the case file
  logic                 exp_mispredict;
  logic [`BP_PC_W-1:0]  exp_redirect;
  int                   error_count;
  int                   check_count;

  // Case file columns
  logic [15:0] c_en  [MAX_CASES];
  logic [15:0] c_fv  [MAX_CASES];
  logic [15:0] c_pc  [MAX_CASES];
  logic [15:0] c_bv  [MAX_CASES];
  logic [15:0] c_at  [MAX_CASES];
  logic [15:0] c_tgt [MAX_CASES];
  logic [15:0] c_mp  [MAX_CASES];
  logic [15:0] c_rd  [MAX_CASES];
  int          n_cases;
  logic        cases_loaded;

  // Aliasing PCs spread over indices 0 to 3
  logic [15:0] pc_pool  [12] = '{16'h0010, 16'h0020, 16'h0030, 16'h0050,
                                 16'h0012, 16'h0022, 16'h0034, 16'h0104,
                                 16'h0114, 16'h0206, 16'h0216, 16'h0046};
  logic [15:0] tgt_pool [4]  = '{16'h0100, 16'h0200, 16'h0300, 16'h0014};

  ////////////////////
  // Clock and DUT
  ////////////////////

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;               // 4 ns period
  end

  branch_predictor u_dut (
    .clk              (clk),
    .rst              (rst),
    .enable           (enable),
    .fetch_valid      (fetch_valid),
    .pc_fetch         (pc_fetch),
    .predicted_taken  (predicted_taken),
    .predicted_target (predicted_target),
    .branch_valid     (branch_valid),
    .actual_taken     (actual_taken),
    .actual_target    (actual_target),
    .mispredict       (mispredict),
    .redirect_pc      (redirect_pc),
    .resolve_kind     (resolve_kind)
  );

  bp_checker u_check (
    .clk              (clk),
    .rst              (rst),
    .enable           (enable),
    .fetch_valid      (fetch_valid),
    .pc_fetch         (pc_fetch),
    .predicted_taken  (predicted_taken),
    .predicted_target (predicted_target),
    .branch_valid     (branch_valid),
    .actual_taken     (actual_taken),
    .actual_target    (actual_target),
    .mispredict       (mispredict),
    .redirect_pc      (redirect_pc),
    .resolve_kind     (resolve_kind),
    .exp_valid        (exp_valid),
    .exp_mispredict   (exp_mispredict),
    .exp_redirect     (exp_redirect),
    .error_count      (error_count),
    .check_count      (check_count)
  );

  ////////////////////
  // Watchdog
  ////////////////////

  initial begin
    wait (cases_loaded);
    #((n_cases + RAND_CYCLES + 20) * 4);
    $display("timeout: the tests did not finish in the expected time");
    $display("sim failed");
    $finish;
  end

  ////////////////////
  // Stimulus
  ////////////////////

  // Idle cycle that keeps the pipeline advancing
  task automatic drive_idle();
    enable       <= 1'b1;
    fetch_valid  <= 1'b0;
    pc_fetch     <= '0;
    branch_valid <= 1'b0;
    actual_taken <= 1'b0;
    actual_target <= '0;
    exp_valid    <= 1'b0;
  endtask

  initial begin : main
    int          fd;
    int          got;
    int          errs_before;
    int          pick;
    logic [31:0] r;
    string       line;
    logic [15:0] f [8];

    void'($urandom(32'h19f8_c09c));      // Single seed for the run
    rst = 1'b1;
    enable = 1'b1;
    fetch_valid = 1'b0;
    pc_fetch = '0;
    branch_valid = 1'b0;
    actual_taken = 1'b0;
    actual_target = '0;
    exp_valid = 1'b0;
    exp_mispredict = 1'b0;
    exp_redirect = '0;
    n_cases = 0;
    cases_loaded = 1'b0;

    fd = $fopen("tb/bp_cases.txt", "r");
    if (fd == 0) begin
      $display("could not open the case file tb/bp_cases.txt");
    end else begin
      while (!$feof(fd) && n_cases < MAX_CASES) begin
        if ($fgets(line, fd) > 0 && line.len() > 1 && line.getc(0) != "/") begin
          got = $sscanf(line, "%h %h %h %h %h %h %h %h",
                        f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7]);
          if (got == 8) begin
            c_en[n_cases] = f[0];
            c_fv[n_cases] = f[1];
            c_pc[n_cases] = f[2];
            c_bv[n_cases] = f[3];
            c_at[n_cases] = f[4];
            c_tgt[n_cases] = f[5];
            c_mp[n_cases] = f[6];
            c_rd[n_cases] = f[7];
            n_cases++;
          end
        end
      end
      $fclose(fd);
    end
    if (n_cases == 0) begin
      $display("no case lines were read from tb/bp_cases.txt");
    end
    cases_loaded = 1'b1;

    repeat (5) @(posedge clk);
    rst <= 1'b0;                         // Held through 5 rising edges

    // Directed cases from the file
    errs_before = error_count;
    for (int i = 0; i < n_cases; i++) begin
      @(posedge clk);
      enable         <= c_en[i][0];
      fetch_valid    <= c_fv[i][0];
      pc_fetch       <= c_pc[i];
      branch_valid   <= c_bv[i][0];
      actual_taken   <= c_at[i][0];
      actual_target  <= c_tgt[i];
      exp_valid      <= 1'b1;
      exp_mispredict <= c_mp[i][0];
      exp_redirect   <= c_rd[i];
    end
    @(posedge clk);
    drive_idle();
    @(negedge clk);
    @(posedge clk);                      // Checker is done with the falling edge
    $display("case file: %0d lines, %0d errors", n_cases, error_count - errs_before);

    // Random traffic over aliasing PCs
    errs_before = error_count;
    for (int i = 0; i < RAND_CYCLES; i++) begin
      @(posedge clk);
      r = $urandom;
      pick = int'(r % 32'd12);
      enable        <= (r[7:5] != 3'd0);  // Stall about one cycle in eight
      fetch_valid   <= (r[9:8] != 2'd0);
      pc_fetch      <= pc_pool[pick];
      branch_valid  <= r[10];
      actual_taken  <= r[11];
      actual_target <= tgt_pool[r[13:12]];
      exp_valid     <= 1'b0;
    end
    @(posedge clk);
    drive_idle();
    @(negedge clk);
    @(posedge clk);
    $display("random: %0d cycles, %0d errors", RAND_CYCLES, error_count - errs_before);

    $display("total: %0d checks, %0d errors", check_count, error_count);
    if (error_count == 0 && n_cases > 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
